/* merc_pkg.sv */
// shared definitions for the LT2208 capture path
// buffer geometry, FX2 endpoint address, sample and FX2 control structs
`default_nettype none

package merc_pkg;

	// capture buffer geometry
	localparam int buf_aw    = 12;            // address bits of the sample RAM
	localparam int buf_depth = 1 << buf_aw;   // words per capture block, 4096

	// FX2 slave FIFO address lines, 2'b10 selects EP6
	localparam logic [1:0] ep6_fifo_adr = 2'd2;

	// one ADC sample, also one word on the FX2 data bus
	typedef logic [15:0] adc_word_t;

	// registered ADC word with its strobe
	typedef struct packed {
		adc_word_t data;    // derandomized sample
		logic      valid;   // sample strobe, delayed with data
	} adc_sample_t;

	// FX2 slave FIFO control pins, strobes all active low
	typedef struct packed {
		logic       slwr;      // write strobe
		logic       slrd;      // read strobe, unused here
		logic       sloe;      // FX2 output enable, unused here
		logic       pkend;     // packet end, held off
		logic [1:0] fifo_adr;  // endpoint select
	} fx2_ctrl_t;

	// idle pin state, write strobe released and EP6 selected
	localparam fx2_ctrl_t fx2_ctrl_idle = '{
		slwr:     1'b1,
		slrd:     1'b1,
		sloe:     1'b1,
		pkend:    1'b1,
		fifo_adr: ep6_fifo_adr
	};

endpackage

`default_nettype wire

/* adc_derandomizer.sv */
// LT2208 input register
// registers the ADC word with its strobe and removes the output randomizer
`timescale 1ns/1ps
`default_nettype none

module adc_derandomizer import merc_pkg::*; (
	input  wire         IFCLK,
	input  wire         rst,
	input  wire  adc_word_t adc,        // raw ADC pins
	input  wire         adc_valid,      // sample strobe from the ADC side
	input  wire         rand_en,        // randomizer is on in the LT2208
	output adc_sample_t clean_sample
);

	adc_word_t plain_word;

	// the randomizer XORs bits 15..1 with bit 0, so the same rule undoes it
	always_comb begin
		if (rand_en && adc[0])
			plain_word = {~adc[15:1], adc[0]};
		else
			plain_word = adc;   // randomizer off or bit 0 clear
	end

	// strobe is control, cleared so nothing reaches the RAM before real data
	always_ff @(posedge IFCLK) begin
		if (rst)
			clean_sample.valid <= 1'b0;
		else
			clean_sample.valid <= adc_valid;
	end

	always_ff @(posedge IFCLK) begin
		clean_sample.data <= plain_word;   // payload, no reset
	end

endmodule

`default_nettype wire

/* sample_buffer.sv */
// capture block RAM
// one write port from the ADC path, one registered read port to the FX2 bus
`timescale 1ns/1ps
`default_nettype none

module sample_buffer import merc_pkg::*; (
	input  wire              IFCLK,
	input  wire              wr_en,
	input  wire [buf_aw-1:0] wr_addr,
	input  wire  adc_word_t  wr_data,
	input  wire [buf_aw-1:0] rd_addr,
	output adc_word_t        rd_data
);

	adc_word_t mem [buf_depth];   // one full capture block

	// write side, one sample per enabled cycle
	always_ff @(posedge IFCLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read side is registered, word shows one cycle after the address
	always_ff @(posedge IFCLK) begin
		rd_data <= mem[rd_addr];
	end

	// an X on the enable would corrupt an unknown RAM location
	a_wr_en_known: assert property (
		@(posedge IFCLK) !$isunknown(wr_en)
	) else $error("sample_buffer: wr_en is unknown");

endmodule

`default_nettype wire

/* capture_sequencer.sv */
// capture and readout sequencer
// idle -> capture one block of valid samples -> read it out word by word
// owns both RAM addresses and the busy level
`timescale 1ns/1ps
`default_nettype none

module capture_sequencer import merc_pkg::*; (
	input  wire               IFCLK,
	input  wire               rst,
	input  wire               arm,           // one-cycle start pulse
	input  wire  adc_sample_t clean_sample,
	input  wire               word_taken,    // writer finished one FX2 word
	output logic              wr_en,
	output logic [buf_aw-1:0] wr_addr,
	output logic [buf_aw-1:0] rd_addr,
	output logic              send,          // readout request to the writer
	output logic              busy
);

	typedef enum logic [1:0] {
		ph_idle    = 2'd0,
		ph_capture = 2'd1,
		ph_readout = 2'd2
	} phase_t;

	phase_t phase;
	logic   wr_last;   // this write fills the block
	logic   rd_last;   // this word is the last of the block

	// the addresses double as written and sent counts
	assign wr_last = (wr_addr == buf_aw'(buf_depth - 1));
	assign rd_last = (rd_addr == buf_aw'(buf_depth - 1));

	// only strobed samples are stored, and only while capturing
	assign wr_en = clean_sample.valid && (phase == ph_capture);

	assign send = (phase == ph_readout);
	assign busy = (phase != ph_idle);     // high from arm until the last word is out

	always_ff @(posedge IFCLK) begin
		if (rst) begin
			phase   <= ph_idle;
			wr_addr <= '0;
			rd_addr <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					// arm outside idle never gets here, so it is ignored while busy
					if (arm) begin
						phase   <= ph_capture;
						wr_addr <= '0;
						rd_addr <= '0;   // word 0 is already on the bus at readout
					end
				end
				ph_capture: begin
					if (wr_en) begin
						wr_addr <= wr_addr + 1'b1;
						if (wr_last)
							phase <= ph_readout;   // block full
					end
				end
				ph_readout: begin
					// next word settles on fx2_fd while the writer waits in state 0
					if (word_taken) begin
						rd_addr <= rd_addr + 1'b1;
						if (rd_last)
							phase <= ph_idle;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// the writer only starts a word while send is high, and send drops only
	// on the last word_taken, so a stray pulse means the two FSMs disagree
	a_taken_in_readout: assert property (
		@(posedge IFCLK) disable iff (rst)
		word_taken |-> (phase == ph_readout)
	) else $error("capture_sequencer: word_taken outside readout");

	// buffer must not change under the read port during readout
	a_wr_only_capture: assert property (
		@(posedge IFCLK) disable iff (rst)
		(phase != ph_capture) |-> !wr_en
	) else $error("capture_sequencer: RAM write outside capture");

endmodule

`default_nettype wire

/* fx2_ep6_writer.sv */
// FX2 slave FIFO write strobe for EP6
// wait for room, pulse SLWR low one cycle, release it and report the word taken
`timescale 1ns/1ps
`default_nettype none

module fx2_ep6_writer import merc_pkg::*; (
	input  wire       IFCLK,
	input  wire       rst,
	input  wire       send,        // words are waiting in the buffer
	input  wire       flagc,       // EP6 not full, high when it takes a word
	output fx2_ctrl_t fx2_ctrl,
	output logic      word_taken   // one cycle, after SLWR went back high
);

	typedef enum logic [1:0] {
		st_wait   = 2'd0,   // SLWR high, waiting for send and room
		st_strobe = 2'd1,   // SLWR low, FX2 takes fx2_fd
		st_done   = 2'd2    // SLWR high again, word_taken pulse
	} wr_state_t;

	wr_state_t state;

	always_ff @(posedge IFCLK) begin
		if (rst) begin
			state      <= st_wait;
			fx2_ctrl   <= fx2_ctrl_idle;
			word_taken <= 1'b0;
		end else begin
			// read side of the FX2 is never used
			fx2_ctrl.slrd     <= 1'b1;
			fx2_ctrl.sloe     <= 1'b1;
			fx2_ctrl.pkend    <= 1'b1;              // FX2 commits full packets itself
			fx2_ctrl.fifo_adr <= ep6_fifo_adr;
			case (state)
				st_wait: begin
					word_taken <= 1'b0;
					// flagc only looked at here, a word once begun always completes
					if (send && flagc) begin
						fx2_ctrl.slwr <= 1'b0;
						state         <= st_strobe;
					end else begin
						fx2_ctrl.slwr <= 1'b1;          // hold off while full
					end
				end
				st_strobe: begin
					fx2_ctrl.slwr <= 1'b1;             // FX2 latched on this edge
					word_taken    <= 1'b1;
					state         <= st_done;
				end
				st_done: begin
					word_taken <= 1'b0;
					state      <= st_wait;              // gives the RAM a cycle for the next word
				end
				default: begin
					fx2_ctrl.slwr <= 1'b1;
					word_taken    <= 1'b0;
					state         <= st_wait;
				end
			endcase
		end
	end

	// one strobe per word, a double strobe would push the same word twice
	a_slwr_single: assert property (
		@(posedge IFCLK) disable iff (rst)
		!fx2_ctrl.slwr |=> fx2_ctrl.slwr
	) else $error("fx2_ep6_writer: SLWR low for two cycles");

endmodule

`default_nettype wire

/* merc_capture_top.sv */
// LT2208 block capture to FX2 EP6, top level
// ADC register -> block RAM -> FX2 slave FIFO, all on IFCLK
`timescale 1ns/1ps
`default_nettype none

module merc_capture_top import merc_pkg::*; (
	input  wire             IFCLK,     // FX2 interface clock
	input  wire             rst,
	input  wire  adc_word_t adc,       // LT2208 data pins
	input  wire             adc_valid,
	input  wire             rand_en,   // LT2208 randomizer enabled
	input  wire             arm,
	input  wire             flagc,     // EP6 not full
	output adc_word_t       fx2_fd,    // FX2 data bus
	output logic            slwr,
	output logic            slrd,
	output logic            sloe,
	output logic            pkend,
	output logic [1:0]      fifo_adr,
	output logic            busy,
	output logic [3:0]      led        // debug LEDs
);

	adc_sample_t       clean_sample;
	fx2_ctrl_t         fx2_ctrl;
	logic              wr_en;
	logic [buf_aw-1:0] wr_addr;
	logic [buf_aw-1:0] rd_addr;
	logic              send;
	logic              word_taken;

	adc_derandomizer u_derand (
		.IFCLK        (IFCLK),
		.rst          (rst),
		.adc          (adc),
		.adc_valid    (adc_valid),
		.rand_en      (rand_en),
		.clean_sample (clean_sample)
	);

	// RAM read data goes straight to the pins
	sample_buffer u_buf (
		.IFCLK   (IFCLK),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (clean_sample.data),
		.rd_addr (rd_addr),
		.rd_data (fx2_fd)
	);

	capture_sequencer u_seq (
		.IFCLK        (IFCLK),
		.rst          (rst),
		.arm          (arm),
		.clean_sample (clean_sample),
		.word_taken   (word_taken),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.rd_addr      (rd_addr),
		.send         (send),
		.busy         (busy)
	);

	fx2_ep6_writer u_wr (
		.IFCLK      (IFCLK),
		.rst        (rst),
		.send       (send),
		.flagc      (flagc),
		.fx2_ctrl   (fx2_ctrl),
		.word_taken (word_taken)
	);

	// FX2 control pins
	assign slwr     = fx2_ctrl.slwr;
	assign slrd     = fx2_ctrl.slrd;
	assign sloe     = fx2_ctrl.sloe;
	assign pkend    = fx2_ctrl.pkend;
	assign fifo_adr = fx2_ctrl.fifo_adr;

	assign led = {2'b00, busy, ~flagc};   // led0 lights while EP6 is full

endmodule

`default_nettype wire

/* merc_capture_tb.sv */
// directed testbench for the LT2208 block capture to FX2 EP6
// drives ADC samples, collects every FX2 write and compares against the driven block
`timescale 1ns/1ps
`default_nettype none

module merc_capture_tb import merc_pkg::*; ();

	localparam int n_blocks    = 4;                 // capture blocks over all tests
	localparam int cap_est     = 2 * buf_depth;     // strobe gaps at most double a capture
	localparam int rd_est      = 6 * buf_depth;     // 3 cycles per word plus EP6 full time
	localparam int cycle_limit = 4 * (n_blocks * (cap_est + rd_est) + 1000);

	logic       IFCLK;
	logic       rst;
	adc_word_t  adc;
	logic       adc_valid;
	logic       rand_en;
	logic       arm;
	logic       flagc;
	adc_word_t  fx2_fd;
	logic       slwr;
	logic       slrd;
	logic       sloe;
	logic       pkend;
	logic [1:0] fifo_adr;
	logic       busy;
	logic [3:0] led;

	fx2_ctrl_t   ctrl_pins;        // FX2 pins gathered back into one word
	adc_word_t   got_q [$];        // words seen on fx2_fd under SLWR
	adc_word_t   exp_q [$];        // words driven in their plain form
	int          got_base;         // first got_q entry of the current block
	logic [31:0] rng_state;
	logic        mon_on;           // monitor runs once reset is released
	logic        prev_slwr;
	logic        prev_flagc;
	int          cycle_count = 0;

	merc_capture_top UUT (
		.IFCLK     (IFCLK),
		.rst       (rst),
		.adc       (adc),
		.adc_valid (adc_valid),
		.rand_en   (rand_en),
		.arm       (arm),
		.flagc     (flagc),
		.fx2_fd    (fx2_fd),
		.slwr      (slwr),
		.slrd      (slrd),
		.sloe      (sloe),
		.pkend     (pkend),
		.fifo_adr  (fifo_adr),
		.busy      (busy),
		.led       (led)
	);

	assign ctrl_pins = {slwr, slrd, sloe, pkend, fifo_adr};

	initial begin
		IFCLK = 1'b0;
		forever #50 IFCLK = ~IFCLK;   // 100 ns IFCLK
	end

	// run limit
	always @(posedge IFCLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still going after %0d clock cycles", cycle_count);
			$display("Finished with errors");
			$fatal(1, "run limit reached");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// pin form of a word with the LT2208 randomizer on
	function automatic adc_word_t randomized_form(input adc_word_t w);
		if (w[0])
			return {~w[15:1], w[0]};   // bit 0 set flips the upper bits
		return w;
	endfunction

	// pins expected outside a strobe, slwr taken as given
	function automatic fx2_ctrl_t ctrl_expect(input logic wr);
		fx2_ctrl_t c;
		c.slwr     = wr;
		c.slrd     = 1'b1;
		c.sloe     = 1'b1;
		c.pkend    = 1'b1;
		c.fifo_adr = ep6_fifo_adr;
		return c;
	endfunction

	task automatic check_word(input adc_word_t got, input adc_word_t exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_ctrl(input fx2_ctrl_t got, input fx2_ctrl_t exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1, "FX2 control mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1, "level mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp, input string msg);
		if (got != exp) begin
			$display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1, "count mismatch");
		end
	endtask

	// FX2 side monitor, sampled mid-cycle where every output is settled
	always @(negedge IFCLK) begin
		if (mon_on) begin
			if (slwr === 1'b0)
				got_q.push_back(fx2_fd);   // FX2 latches the bus during the strobe
			// flagc seen one negedge earlier is what the writer sampled
			if (slwr === 1'b0 && prev_slwr === 1'b1)
				check_bit(prev_flagc, 1'b1, "SLWR began while EP6 was full");
			check_ctrl(ctrl_pins, ctrl_expect(slwr), "FX2 read, pkend or address pins");
			check_bit(led[0], ~flagc, "led0 against EP6 full");
			check_bit(led[1], busy, "led1 against busy");
			check_bit(|led[3:2], 1'b0, "unused LEDs");
		end
		prev_slwr  = slwr;
		prev_flagc = flagc;
	end

	// one input cycle, driven just after the rising edge
	task automatic drive_cycle(input adc_word_t w, input logic v, input logic a);
		@(posedge IFCLK);
		#10;
		adc       = w;
		adc_valid = v;
		arm       = a;
	endtask

	task automatic set_mode(input logic r, input logic f);
		@(posedge IFCLK);
		#10;
		rand_en = r;
		flagc   = f;
	endtask

	task automatic reset_dut;
		rst = 1'b1;
		repeat (16) @(posedge IFCLK);
		#10;
		rst    = 1'b0;
		mon_on = 1'b1;
	endtask

	task automatic pulse_arm;
		drive_cycle(16'h0000, 1'b0, 1'b1);
		drive_cycle(16'h0000, 1'b0, 1'b0);
		@(negedge IFCLK);
		check_bit(busy, 1'b1, "busy one edge after arm");
	endtask

	// one block of valid samples, random data or a ramp, optional strobe gaps
	task automatic capture_block(input logic random_data, input logic gaps, input int arm_at);
		logic [31:0] r;
		adc_word_t   orig;
		int          gap;
		got_base = got_q.size();
		exp_q.delete();
		for (int i = 0; i < buf_depth; i++) begin
			next_rand(r);
			gap = (gaps && r[2:0] == 3'd0) ? int'(r[4:3]) + 1 : 0;
			repeat (gap) drive_cycle(r[31:16], 1'b0, 1'b0);   // junk with the strobe low
			orig = random_data ? adc_word_t'(r[31:16]) : adc_word_t'(i);
			drive_cycle(rand_en ? randomized_form(orig) : orig, 1'b1, (i == arm_at));
			exp_q.push_back(orig);
		end
		repeat (4) drive_cycle(16'hdead, 1'b1, 1'b0);   // past the block, never stored
		drive_cycle(16'h0000, 1'b0, 1'b0);
	endtask

	// EP6 full at random cycles until the block is out
	task automatic throttle_readout;
		logic [31:0] r;
		while (got_q.size() - got_base < buf_depth) begin
			next_rand(r);
			flagc = (r[1:0] != 2'd0);
			@(posedge IFCLK);
			#10;
		end
		flagc = 1'b1;
	endtask

	// busy drops on the edge after the last word_taken
	task automatic wait_block_out(input string name);
		while (got_q.size() - got_base < buf_depth)
			@(posedge IFCLK);
		@(negedge IFCLK);
		check_bit(busy, 1'b1, {name, ": busy while the last word is taken"});
		@(negedge IFCLK);
		check_bit(busy, 1'b0, {name, ": busy after readout"});
	endtask

	task automatic check_block(input string name);
		check_count(got_q.size() - got_base, buf_depth, {name, ": FX2 words written"});
		for (int i = 0; i < buf_depth; i++)
			check_word(got_q[got_base + i], exp_q[i], $sformatf("%s: word %0d", name, i));
	endtask

	task automatic idle_after_reset;
		@(negedge IFCLK);
		check_ctrl(ctrl_pins, ctrl_expect(1'b1), "FX2 pins after reset");
		check_bit(busy, 1'b0, "busy after reset");
		repeat (50) @(negedge IFCLK);
		check_count(got_q.size(), 0, "SLWR pulses without arm");
	endtask

	task automatic ramp_readout;
		set_mode(1'b0, 1'b1);
		pulse_arm;
		capture_block(1'b0, 1'b0, -1);
		wait_block_out("ramp");
		check_block("ramp");
	endtask

	task automatic randomizer_removal;
		set_mode(1'b1, 1'b1);   // words arrive in randomized pin form
		pulse_arm;
		capture_block(1'b1, 1'b0, -1);
		wait_block_out("randomizer");
		check_block("randomizer");
	endtask

	task automatic backpressure_readout;
		set_mode(1'b0, 1'b1);
		pulse_arm;
		capture_block(1'b0, 1'b0, -1);
		throttle_readout;
		wait_block_out("EP6 full");
		check_block("EP6 full");
	endtask

	task automatic gaps_and_rearm;
		set_mode(1'b0, 1'b1);
		pulse_arm;
		capture_block(1'b1, 1'b1, buf_depth / 2);   // arm again halfway through capture
		drive_cycle(16'h0000, 1'b0, 1'b1);          // and once more during readout
		drive_cycle(16'h0000, 1'b0, 1'b0);
		@(negedge IFCLK);
		check_bit(busy, 1'b1, "busy during readout");
		wait_block_out("valid gaps");
		repeat (100) @(negedge IFCLK);   // a second block would show up here
		check_block("valid gaps");
	endtask

	initial begin
		rst        = 1'b1;
		adc        = '0;
		adc_valid  = 1'b0;
		rand_en    = 1'b0;
		arm        = 1'b0;
		flagc      = 1'b1;
		mon_on     = 1'b0;
		got_base   = 0;
		rng_state  = 32'd95;
		prev_slwr  = 1'b1;
		prev_flagc = 1'b1;
		reset_dut;
		idle_after_reset;
		ramp_readout;
		randomizer_removal;
		backpressure_readout;
		gaps_and_rearm;
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
merc_pkg.sv
adc_derandomizer.sv
sample_buffer.sv
capture_sequencer.sv
fx2_ep6_writer.sv
merc_capture_top.sv
merc_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	-f sim.f \
	--top-module merc_capture_tb \
	-Mdir obj_dir -o merc_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/merc_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Finished with no errors$" "$SIM_LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
